// File: verif/conv_load_stim.txt
# F busy done | A pe acc | R sel rdata | C sel wdata rdata | P first count | W addr data
# S latency extra (decimal cycles, extra 0 = no second start); other fields hex
F 0 0
A 0 00000
A 1 00000
A 2 00000
A 3 00000
R 0 00
R 1 03
# Memory holds address plus one, with four bytes raised to ff.
P 00 40
W 24 ff
W 25 ff
W 36 ff
W 37 ff
# Three taps from base 0.
C 0 00 00
C 1 03 03
S 26 0
A 0 0002c
A 1 00116
A 2 002d8
A 3 00572
# Base 16, taps written as 0.
C 0 10 10
C 1 00 01
S 10 0
A 0 00132
A 1 0017c
A 2 001ce
A 3 00228
# Taps written as 9, clipped to 7.
C 0 00 00
C 1 09 07
S 58 0
A 0 001f8
A 1 00d12
A 2 11b67
A 3 13567
# Second start while busy, at cycle 5.
C 0 20 20
C 1 02 02
S 18 5
A 0 0094e
A 1 10419
A 2 00e1e
A 3 010e6
# Second start in the done cycle.
C 0 00 00
C 1 01 01
S 10 10
A 0 00002
A 1 0000c
A 2 0001e
A 3 00038

// File: src.f
design/pe_data_pkg.sv
design/loader_ctrl_pkg.sv
design/loader_cfg_regs.sv
design/data_loader.sv
design/operand_mem.sv
design/mac_array.sv
design/conv_load_top.sv
verif/tb_clk_gen.sv
verif/tb_conv_load.sv

// File: run.sh
#!/usr/bin/env bash
# Builds and runs the conv_load testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    --top-module tb_conv_load \
    -f src.f \
    -o sim_conv_load

./obj_dir/sim_conv_load

// File: verif/tb_conv_load.sv
`default_nettype none

module tb_conv_load;

    import pe_data_pkg::*;

    localparam int    NUM_PE     = NUM_PE_DEF;
    localparam int    ADDR_W     = ADDR_W_DEF;
    localparam int    PE_W       = $clog2(NUM_PE);
    localparam int    MAX_CYCLES = 4000;  // Tests need about 210 cycles.
    localparam string STIM_FILE  = "verif/conv_load_stim.txt";

    logic              clk;
    logic              rst_i;
    logic              mem_we_i;
    logic [ADDR_W-1:0] mem_waddr_i;
    operand_t          mem_wdata_i;
    logic              cfg_we_i;
    logic              cfg_sel_i;
    logic [7:0]        cfg_wdata_i;
    logic [7:0]        cfg_rdata_o;
    logic              start_i;
    logic              busy_o;
    logic              done_o;
    acc_t              acc_o [NUM_PE];

    int cycle_cnt = 0;
    int n_checks  = 0;

    tb_clk_gen #(
        .PERIOD (100)
    ) i_clk (
        .clk_o (clk)
    );

    conv_load_top #(
        .NUM_PE (NUM_PE),
        .ADDR_W (ADDR_W)
    ) i_dut (
        .clk         (clk),
        .rst_i       (rst_i),
        .mem_we_i    (mem_we_i),
        .mem_waddr_i (mem_waddr_i),
        .mem_wdata_i (mem_wdata_i),
        .cfg_we_i    (cfg_we_i),
        .cfg_sel_i   (cfg_sel_i),
        .cfg_wdata_i (cfg_wdata_i),
        .cfg_rdata_o (cfg_rdata_o),
        .start_i     (start_i),
        .busy_o      (busy_o),
        .done_o      (done_o),
        .acc_o       (acc_o)
    );

    task automatic stop_on_error();
        $display(">>> FAIL");
        $fatal(1, "Stopped at the first error.");
    endtask

    task automatic check_acc(input int pe, input acc_t got, input acc_t exp);
        n_checks++;
        if (got !== exp) begin
            $display("Fail acc_o[%0d]: got %h, expected %h", pe, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_cfg(input logic sel, input logic [7:0] got, input logic [7:0] exp);
        n_checks++;
        if (got !== exp) begin
            $display("Fail cfg_rdata_o (sel %0d): got %h, expected %h", sel, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic bad_line(input string line);
        $display("Malformed line in the stimulus file: %s", line);
        stop_on_error();
    endtask

    task automatic mem_write(input logic [ADDR_W-1:0] addr, input operand_t data);
        mem_we_i    = 1'b1;
        mem_waddr_i = addr;
        mem_wdata_i = data;
        @(negedge clk);
        mem_we_i = 1'b0;
    endtask

    task automatic fill_memory(input int first, input int count);
        for (int a = first; a < first + count; a++) begin
            mem_write(ADDR_W'(a), operand_t'(a + 1));  // Value is address plus one.
        end
    endtask

    task automatic write_cfg(input logic sel, input logic [7:0] data, input logic [7:0] exp);
        cfg_we_i    = 1'b1;
        cfg_sel_i   = sel;
        cfg_wdata_i = data;
        @(negedge clk);
        cfg_we_i = 1'b0;
        check_cfg(sel, cfg_rdata_o, exp);
    endtask

    task automatic read_cfg(input logic sel, input logic [7:0] exp);
        cfg_sel_i = sel;
        @(negedge clk);
        check_cfg(sel, cfg_rdata_o, exp);
    endtask

    // Start pulse, then an optional second start while busy.
    task automatic run_conv(input int latency, input int extra);
        int cycles;
        start_i = 1'b1;
        for (cycles = 1; cycles <= latency; cycles++) begin
            @(negedge clk);
            if (cycles == 1) begin
                for (int p = 0; p < NUM_PE; p++) begin
                    check_acc(p, acc_o[PE_W'(p)], '0);  // Cleared by the start.
                end
            end
            check_flag($sformatf("busy_o at cycle %0d", cycles), busy_o, 1'b1);
            check_flag($sformatf("done_o at cycle %0d", cycles), done_o, cycles == latency);
            start_i = (cycles == extra);
        end
        @(negedge clk);
        start_i = 1'b0;
        check_flag("busy_o after done", busy_o, 1'b0);
        check_flag("done_o after done", done_o, 1'b0);
    endtask

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: the tests ran past %0d cycles.", MAX_CYCLES);
            stop_on_error();
        end
    end

    initial begin
        int          fd;
        int          n;
        string       line;
        string       op;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        rst_i       = 1'b1;
        mem_we_i    = 1'b0;
        mem_waddr_i = '0;
        mem_wdata_i = '0;
        cfg_we_i    = 1'b0;
        cfg_sel_i   = 1'b0;
        cfg_wdata_i = '0;
        start_i     = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file %s.", STIM_FILE);
            stop_on_error();
        end
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%s", op);
            if (n != 1 || op == "#") begin
                continue;  // Blank or comment.
            end
            if (op == "F") begin
                n = $sscanf(line, "%s %h %h", op, f1, f2);
                if (n != 3) bad_line(line);
                check_flag("busy_o", busy_o, f1[0]);
                check_flag("done_o", done_o, f2[0]);
            end else if (op == "A") begin
                n = $sscanf(line, "%s %h %h", op, f1, f2);
                if (n != 3 || f1 >= NUM_PE) bad_line(line);
                check_acc(int'(f1), acc_o[PE_W'(f1)], acc_t'(f2));
            end else if (op == "R") begin
                n = $sscanf(line, "%s %h %h", op, f1, f2);
                if (n != 3) bad_line(line);
                read_cfg(f1[0], f2[7:0]);
            end else if (op == "C") begin
                n = $sscanf(line, "%s %h %h %h", op, f1, f2, f3);
                if (n != 4) bad_line(line);
                write_cfg(f1[0], f2[7:0], f3[7:0]);
            end else if (op == "P") begin
                n = $sscanf(line, "%s %h %h", op, f1, f2);
                if (n != 3) bad_line(line);
                fill_memory(int'(f1), int'(f2));
            end else if (op == "W") begin
                n = $sscanf(line, "%s %h %h", op, f1, f2);
                if (n != 3) bad_line(line);
                mem_write(ADDR_W'(f1), operand_t'(f2));
            end else if (op == "S") begin
                n = $sscanf(line, "%s %d %d", op, f1, f2);
                if (n != 3) bad_line(line);
                run_conv(int'(f1), int'(f2));
            end else begin
                bad_line(line);
            end
        end
        $fclose(fd);

        if (n_checks == 0) begin
            $display("No checks were found in the stimulus file.");
            stop_on_error();
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: verif/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD = 100
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

// File: design/conv_load_top.sv
`default_nettype none

module conv_load_top #(
    parameter int NUM_PE = pe_data_pkg::NUM_PE_DEF,
    parameter int ADDR_W = pe_data_pkg::ADDR_W_DEF
) (
    input  wire logic                  clk,
    input  wire logic                  rst_i,
    input  wire logic                  mem_we_i,
    input  wire logic [ADDR_W-1:0]     mem_waddr_i,
    input  wire pe_data_pkg::operand_t mem_wdata_i,
    input  wire logic                  cfg_we_i,
    input  wire logic                  cfg_sel_i,
    input  wire logic [7:0]            cfg_wdata_i,
    output logic      [7:0]            cfg_rdata_o,
    input  wire logic                  start_i,
    output logic                       busy_o,
    output logic                       done_o,
    output pe_data_pkg::acc_t          acc_o [NUM_PE]
);

    import pe_data_pkg::*;
    import loader_ctrl_pkg::*;

    loader_cfg_t cfg;
    mem_addr_t   rd_addr;
    pe_ctrl_t    ctrl;
    operand_t    mem_rdata;
    logic        clear;

    loader_cfg_regs i_cfg (
        .clk         (clk),
        .rst_i       (rst_i),
        .cfg_we_i    (cfg_we_i),
        .cfg_sel_i   (cfg_sel_i),
        .cfg_wdata_i (cfg_wdata_i),
        .cfg_rdata_o (cfg_rdata_o),
        .cfg_o       (cfg)
    );

    data_loader #(
        .NUM_PE (NUM_PE)
    ) i_loader (
        .clk       (clk),
        .rst_i     (rst_i),
        .start_i   (start_i),
        .cfg_i     (cfg),
        .rd_addr_o (rd_addr),
        .ctrl_o    (ctrl),
        .busy_o    (busy_o),
        .done_o    (done_o),
        .clear_o   (clear)
    );

    operand_mem #(
        .ADDR_W (ADDR_W)
    ) i_mem (
        .clk     (clk),
        .we_i    (mem_we_i),
        .waddr_i (mem_waddr_i),
        .wdata_i (mem_wdata_i),
        .raddr_i (rd_addr),
        .rdata_o (mem_rdata)
    );

    mac_array #(
        .NUM_PE (NUM_PE)
    ) i_mac (
        .clk     (clk),
        .rst_i   (rst_i),
        .clear_i (clear),
        .ctrl_i  (ctrl),
        .data_i  (mem_rdata),
        .acc_o   (acc_o)
    );

endmodule

`default_nettype wire

// File: design/mac_array.sv
`default_nettype none

module mac_array #(
    parameter int NUM_PE = 4
) (
    input  wire logic                      clk,
    input  wire logic                      rst_i,
    input  wire logic                      clear_i,
    input  wire loader_ctrl_pkg::pe_ctrl_t ctrl_i,
    input  wire pe_data_pkg::operand_t     data_i,
    output pe_data_pkg::acc_t              acc_o [NUM_PE]
);

    import pe_data_pkg::*;

    localparam int PROD_W = 2 * OPERAND_W;

    for (genvar g = 0; g < NUM_PE; g++) begin : g_pe
        operand_t          feat_q;
        operand_t          wgt;
        logic [PROD_W-1:0] prod;
        acc_t              acc_q;

        // Only a weight beat feeds the multiplier.
        assign wgt  = ctrl_i.weight_en[g] ? data_i : '0;
        assign prod = feat_q * wgt;

        always_ff @(posedge clk) begin
            if (ctrl_i.feature_en[g]) begin
                feat_q <= data_i;  // Held until the next feature.
            end
        end

        always_ff @(posedge clk) begin
            if (rst_i) begin
                acc_q <= '0;
            end else if (clear_i) begin
                acc_q <= '0;  // New run.
            end else if (ctrl_i.acc_en[g]) begin
                acc_q <= acc_q + acc_t'(prod);
            end
        end

        assign acc_o[g] = acc_q;
    end

endmodule

`default_nettype wire

// File: design/operand_mem.sv
`default_nettype none

module operand_mem #(
    parameter int ADDR_W = 6
) (
    input  wire logic                  clk,
    input  wire logic                  we_i,
    input  wire logic [ADDR_W-1:0]     waddr_i,
    input  wire pe_data_pkg::operand_t wdata_i,
    input  wire logic [ADDR_W-1:0]     raddr_i,
    output pe_data_pkg::operand_t      rdata_o
);

    import pe_data_pkg::*;

    localparam int DEPTH = 2 ** ADDR_W;

    operand_t mem [DEPTH];
    operand_t rdata_q;

    // Host write port.
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // One cycle read latency.
    always_ff @(posedge clk) begin
        rdata_q <= mem[raddr_i];
    end

    assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: design/data_loader.sv
`default_nettype none

module data_loader #(
    parameter int NUM_PE = 4
) (
    input  wire logic                         clk,
    input  wire logic                         rst_i,
    input  wire logic                         start_i,
    input  wire loader_ctrl_pkg::loader_cfg_t cfg_i,
    output pe_data_pkg::mem_addr_t            rd_addr_o,
    output loader_ctrl_pkg::pe_ctrl_t         ctrl_o,
    output logic                              busy_o,
    output logic                              done_o,
    output logic                              clear_o
);

    import pe_data_pkg::*;
    import loader_ctrl_pkg::*;

    localparam int STEP_W = $clog2(2 * NUM_PE * int'(MAX_TAPS));
    localparam int POS_W  = $clog2(2 * int'(MAX_TAPS));
    localparam int PE_W   = $clog2(NUM_PE);

    typedef logic [STEP_W-1:0] step_t;
    typedef logic [POS_W-1:0]  pos_t;
    typedef logic [PE_W-1:0]   pe_idx_t;

    loader_state_t state_q, state_d;
    mem_addr_t     base_q;
    step_t         step_q, step_d;
    step_t         last_step_q;
    pos_t          pos_q, pos_d;
    pos_t          pos_last_q;
    pe_idx_t       pe_q, pe_d;
    pe_mask_t      pe_sel;
    pe_ctrl_t      ctrl_d, ctrl_q;
    logic          start_ok;
    logic          done_q;

    assign busy_o   = (state_q != IDLE) || done_q;
    assign start_ok = start_i && !busy_o;  // Start is dropped while busy.
    assign clear_o  = start_ok;

    // Next step, position inside the PE block and PE index.
    always_comb begin
        state_d = state_q;
        step_d  = step_q;
        pos_d   = pos_q;
        pe_d    = pe_q;
        case (state_q)
            IDLE: begin
                if (start_ok) begin
                    state_d = RUN;
                    step_d  = '0;
                    pos_d   = '0;
                    pe_d    = '0;
                end
            end
            RUN: begin
                if (step_q == last_step_q) begin
                    state_d = DRAIN;  // Last enables still in flight.
                end else begin
                    step_d = step_q + step_t'(1);
                    if (pos_q == pos_last_q) begin
                        pos_d = '0;
                        pe_d  = pe_q + pe_idx_t'(1);
                    end else begin
                        pos_d = pos_q + pos_t'(1);
                    end
                end
            end
            DRAIN: state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    // Decode the step into per-PE enables.
    always_comb begin
        pe_sel         = '0;
        pe_sel[pe_q]   = 1'b1;
        ctrl_d         = '0;
        if (state_q == RUN) begin
            if (pos_q[0]) begin
                ctrl_d.weight_en = pe_sel;
                ctrl_d.acc_en    = pe_sel;
            end else begin
                ctrl_d.feature_en = pe_sel;  // Even steps carry features.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q     <= IDLE;
            base_q      <= '0;
            step_q      <= '0;
            last_step_q <= '0;
            pos_q       <= '0;
            pos_last_q  <= '0;
            pe_q        <= '0;
            ctrl_q      <= '0;
            done_q      <= 1'b0;
        end else begin
            state_q <= state_d;
            step_q  <= step_d;
            pos_q   <= pos_d;
            pe_q    <= pe_d;
            ctrl_q  <= ctrl_d;  // Aligns with the memory read latency.
            done_q  <= (state_q == DRAIN);
            if (start_ok) begin
                base_q      <= cfg_i.base_addr;
                last_step_q <= step_t'(2 * NUM_PE * int'(cfg_i.taps) - 1);
                pos_last_q  <= pos_t'(2 * int'(cfg_i.taps) - 1);
            end
        end
    end

    assign rd_addr_o = base_q + mem_addr_t'(step_q);
    assign ctrl_o    = ctrl_q;
    assign done_o    = done_q;

endmodule

`default_nettype wire

// File: design/loader_cfg_regs.sv
`default_nettype none

module loader_cfg_regs (
    input  wire logic                         clk,
    input  wire logic                         rst_i,
    input  wire logic                         cfg_we_i,
    input  wire logic                         cfg_sel_i,
    input  wire logic [7:0]                   cfg_wdata_i,
    output logic      [7:0]                   cfg_rdata_o,
    output loader_ctrl_pkg::loader_cfg_t      cfg_o
);

    import pe_data_pkg::*;
    import loader_ctrl_pkg::*;

    loader_cfg_t cfg_q;
    tap_cnt_t    taps_wr;

    // Zero is raised to one tap, large values saturate.
    always_comb begin
        if (cfg_wdata_i == 8'd0) begin
            taps_wr = tap_cnt_t'(1);
        end else if (cfg_wdata_i > 8'(MAX_TAPS)) begin
            taps_wr = MAX_TAPS;
        end else begin
            taps_wr = tap_cnt_t'(cfg_wdata_i);
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            cfg_q.base_addr <= '0;
            cfg_q.taps      <= tap_cnt_t'(3);
        end else if (cfg_we_i) begin
            if (cfg_sel_i) begin
                cfg_q.taps <= taps_wr;
            end else begin
                cfg_q.base_addr <= mem_addr_t'(cfg_wdata_i);
            end
        end
    end

    // Readback of the selected register.
    always_comb begin
        if (cfg_sel_i) begin
            cfg_rdata_o = 8'(cfg_q.taps);
        end else begin
            cfg_rdata_o = 8'(cfg_q.base_addr);
        end
    end

    assign cfg_o = cfg_q;

endmodule

`default_nettype wire

// File: design/loader_ctrl_pkg.sv
`default_nettype none

package loader_ctrl_pkg;

    // Tap count register.
    typedef logic [2:0] tap_cnt_t;

    localparam tap_cnt_t MAX_TAPS = 3'd7;

    // Loader sequencing.
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN
    } loader_state_t;

    // Enables toward the MAC array, one bit per PE in each field.
    typedef struct packed {
        pe_data_pkg::pe_mask_t feature_en;
        pe_data_pkg::pe_mask_t weight_en;
        pe_data_pkg::pe_mask_t acc_en;
    } pe_ctrl_t;

    // Run configuration seen by the loader.
    typedef struct packed {
        pe_data_pkg::mem_addr_t base_addr;
        tap_cnt_t               taps;
    } loader_cfg_t;

endpackage

`default_nettype wire

// File: design/pe_data_pkg.sv
`default_nettype none

package pe_data_pkg;

    // Default array geometry used by the top level.
    localparam int NUM_PE_DEF = 4;
    localparam int ADDR_W_DEF = 6;

    // Operand and accumulator widths.
    localparam int OPERAND_W = 8;
    localparam int ACC_W     = 20;  // Holds 7 taps of 255 * 255.

    // Feature or weight byte.
    typedef logic [OPERAND_W-1:0] operand_t;

    // Operand memory address.
    typedef logic [ADDR_W_DEF-1:0] mem_addr_t;

    // Per-PE dot product result.
    typedef logic [ACC_W-1:0] acc_t;

    // One-hot processing element select.
    typedef logic [NUM_PE_DEF-1:0] pe_mask_t;

endpackage

`default_nettype wire
